// ==== cpu16.f ====
rtl/cpu16_pkg.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/core.sv
rtl/cpu16_top.sv
bench/bench_mem.sv
bench/cpu16_tb.sv

// ==== bench/cpu16_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu16_tb;

	localparam int PERIOD = 100;
	localparam int NTESTS = 6;
	localparam int WORDS = 8;
	localparam int CYCLES_PER_TEST = 200;
	localparam logic [31:0] NOP_WORD = 32'hffff_ffff;
	localparam logic [15:0] NOP = 16'hffff;

	localparam cpu16_pkg::op_e ADD = cpu16_pkg::OP_ADD;
	localparam cpu16_pkg::op_e ADC = cpu16_pkg::OP_ADC;
	localparam cpu16_pkg::op_e SUB = cpu16_pkg::OP_SUB;
	localparam cpu16_pkg::op_e MOV = cpu16_pkg::OP_MOV;
	localparam cpu16_pkg::op_e MOVL = cpu16_pkg::OP_MOVL;
	localparam cpu16_pkg::op_e MOVH = cpu16_pkg::OP_MOVH;
	localparam cpu16_pkg::op_e MOVF = cpu16_pkg::OP_MOVF;
	localparam cpu16_pkg::op_e JMP = cpu16_pkg::OP_JMP;
	localparam cpu16_pkg::op_e LD = cpu16_pkg::OP_LD;
	localparam cpu16_pkg::op_e ST = cpu16_pkg::OP_ST;

	logic clk;
	logic reset;
	logic [15:0] instr_addr;
	logic [31:0] instruction;
	cpu16_pkg::mem_req_t mem_req;
	cpu16_pkg::mem_rsp_t mem_rsp;
	logic [15:0] preset_addr;
	logic [15:0] preset;
	int store_count;
	logic [15:0] store_addr;
	logic [15:0] store_data;

	// program words, expected store and load preset for each test
	logic [31:0] prog [NTESTS][WORDS];
	logic [15:0] exp_addr [NTESTS];
	logic [15:0] exp_data [NTESTS];
	logic [15:0] load_addr [NTESTS];
	logic [15:0] load_val [NTESTS];
	logic [31:0] cur_prog [WORDS];
	int errors;
	int failed;

	cpu16_top dut0 (
		.clk(clk),
		.reset(reset),
		.instr_addr(instr_addr),
		.instruction(instruction),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	bench_mem mem0 (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.preset_addr(preset_addr),
		.preset(preset),
		.store_count(store_count),
		.store_addr(store_addr),
		.store_data(store_data)
	);

	always #(PERIOD / 2) clk = ~clk;

	// instruction memory returns nops past the end of the program
	always @(posedge clk) begin
		#1;
		instruction = (instr_addr < WORDS) ? cur_prog[instr_addr] : NOP_WORD;
	end

	// opcode, dest, src and suffix over five unused bits
	function automatic logic [15:0] reg_instr(input cpu16_pkg::op_e op, input logic [2:0] dest,
		input logic [2:0] src, input logic suffix);
		return {op, dest, src, suffix, 5'b00000};
	endfunction

	function automatic logic [15:0] imm_instr(input cpu16_pkg::op_e op, input logic [2:0] dest,
		input logic [7:0] imm);
		return {op, dest, 1'b0, imm};
	endfunction

	// low half runs first
	task automatic set_word(input int t, input int w, input logic [15:0] lo,
		input logic [15:0] hi);
		prog[t][w] = {hi, lo};
	endtask

	task automatic expect_store(input int t, input logic [15:0] addr, input logic [15:0] data,
		input logic [15:0] rd_addr, input logic [15:0] rd_val);
		exp_addr[t] = addr;
		exp_data[t] = data;
		load_addr[t] = rd_addr;
		load_val[t] = rd_val;
	endtask

	task automatic compare(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
			failed = 1;
		end
	endtask

	task automatic fill_table;
		for (int t = 0; t < NTESTS; t++) begin
			for (int w = 0; w < WORDS; w++) begin
				prog[t][w] = NOP_WORD;
			end
		end
		// test 1 builds 0x1234 with immediate moves
		set_word(0, 0, imm_instr(MOVL, 0, 8'h34), imm_instr(MOVH, 0, 8'h12));
		set_word(0, 1, imm_instr(MOVL, 1, 8'h40), reg_instr(ST, 1, 0, 0));
		expect_store(0, 16'h0040, 16'h1234, 16'h0000, 16'h0000);
		// test 2 computes 0x30 + 5 - 0x10 and then subtracts without suffix
		set_word(1, 0, imm_instr(MOVL, 0, 8'h30), imm_instr(MOVL, 1, 8'h05));
		set_word(1, 1, imm_instr(MOVL, 2, 8'h10), imm_instr(MOVL, 3, 8'h41));
		set_word(1, 2, reg_instr(ADD, 0, 1, 1), reg_instr(SUB, 0, 2, 1));
		set_word(1, 3, reg_instr(SUB, 0, 1, 0), reg_instr(ST, 3, 0, 0));
		expect_store(1, 16'h0041, 16'h0025, 16'h0000, 16'h0000);
		// test 3 copies the flags of 0x7fff + 1 and adds 0x8000 with carry
		set_word(2, 0, imm_instr(MOVL, 0, 8'hff), imm_instr(MOVH, 0, 8'h7f));
		set_word(2, 1, imm_instr(MOVL, 1, 8'h01), imm_instr(MOVL, 4, 8'h42));
		set_word(2, 2, reg_instr(ADD, 0, 1, 1), reg_instr(MOVF, 2, 0, 0));
		set_word(2, 3, imm_instr(MOVL, 3, 8'hff), imm_instr(MOVH, 3, 8'hff));
		set_word(2, 4, reg_instr(ADD, 3, 1, 0), reg_instr(ADC, 2, 0, 1));
		set_word(2, 5, reg_instr(ST, 4, 2, 0), NOP);
		expect_store(2, 16'h0042, 16'h8007, 16'h0000, 16'h0000);
		// test 4 moves in a high half and replaces the low byte afterwards
		set_word(3, 0, imm_instr(MOVL, 0, 8'h5a), imm_instr(MOVH, 0, 8'hc3));
		set_word(3, 1, imm_instr(MOVL, 5, 8'h43), reg_instr(MOV, 2, 0, 0));
		set_word(3, 2, imm_instr(MOVL, 2, 8'h77), reg_instr(ST, 5, 2, 0));
		expect_store(3, 16'h0043, 16'hc377, 16'h0000, 16'h0000);
		// test 5 loads r3 from 0x80 and stores it
		set_word(4, 0, imm_instr(MOVL, 1, 8'h80), imm_instr(MOVL, 4, 8'h44));
		set_word(4, 1, reg_instr(LD, 3, 1, 0), reg_instr(ST, 4, 3, 0));
		expect_store(4, 16'h0044, 16'hbeef, 16'h0080, 16'hbeef);
		// test 6 jumps to word 3 over a store of zero
		set_word(5, 0, imm_instr(MOVL, 1, 8'h03), imm_instr(MOVL, 2, 8'h45));
		set_word(5, 1, imm_instr(MOVL, 0, 8'h66), reg_instr(JMP, 0, 1, 0));
		set_word(5, 2, reg_instr(ST, 2, 3, 0), NOP);
		set_word(5, 3, reg_instr(ST, 2, 0, 0), NOP);
		expect_store(5, 16'h0045, 16'h0066, 16'h0000, 16'h0000);
	endtask

	initial begin
		#(NTESTS * CYCLES_PER_TEST * PERIOD);
		$display("timeout: tests did not finish within %0d cycles", NTESTS * CYCLES_PER_TEST);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instruction = NOP_WORD;
		preset_addr = 16'h0000;
		preset = 16'h0000;
		errors = 0;
		fill_table();
		for (int t = 0; t < NTESTS; t++) begin
			failed = 0;
			@(posedge clk);
			#1;
			reset = 1'b1;
			for (int w = 0; w < WORDS; w++) begin
				cur_prog[w] = prog[t][w];
			end
			preset_addr = load_addr[t];
			preset = load_val[t];
			repeat (2) @(posedge clk);
			#1;
			reset = 1'b0;
			while (store_count == 0) @(negedge clk);
			compare(store_addr, exp_addr[t], "store address");
			compare(store_data, exp_data[t], "store data");
			// the program runs on into nops and must not store again
			repeat (8) @(negedge clk);
			compare(16'(store_count), 16'd1, "store count");
			$display("test %0d %s", t + 1, failed ? "failed" : "passed");
		end
		$display("%0d tests run, %0d errors", NTESTS, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/bench_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module bench_mem (
	input wire logic clk,
	input wire logic reset,
	input wire cpu16_pkg::mem_req_t mem_req,
	output cpu16_pkg::mem_rsp_t mem_rsp,
	input wire logic [15:0] preset_addr,
	input wire logic [15:0] preset,
	output int store_count,
	output logic [15:0] store_addr,
	output logic [15:0] store_data
);

	logic [15:0] lfsr;
	logic busy;
	logic [1:0] wait_cnt;
	logic [1:0] delay;

	// galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
	endfunction

	initial begin
		lfsr = 16'd22575;
		mem_rsp = '0;
	end

	always @(posedge clk) begin
		if (reset) begin
			mem_rsp <= '0;
			busy <= 1'b0;
			wait_cnt <= 2'd0;
			store_count <= 0;
		end else if (mem_rsp.response) begin
			// response lasts one cycle and the core drops request on this edge
			mem_rsp.response <= 1'b0;
		end else if (mem_req.request && !busy) begin
			// two bits of extra wait with one lfsr step per bit
			delay[0] = lfsr[0];
			lfsr = lfsr_next(lfsr);
			delay[1] = lfsr[0];
			lfsr = lfsr_next(lfsr);
			busy <= 1'b1;
			wait_cnt <= delay;
		end else if (busy && wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end else if (busy) begin
			busy <= 1'b0;
			mem_rsp.response <= 1'b1;
			if (mem_req.wren) begin
				store_count <= store_count + 1;
				store_addr <= mem_req.address;
				store_data <= mem_req.writedata;
			end else begin
				// any other address reads the inverted preset
				mem_rsp.readdata <= (mem_req.address == preset_addr) ? preset : ~preset;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cpu16_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu16_top (
	input wire logic clk,
	input wire logic reset,
	output wire logic [cpu16_pkg::DATA_WIDTH-1:0] instr_addr,
	input wire logic [cpu16_pkg::WORD_WIDTH-1:0] instruction,
	output wire cpu16_pkg::mem_req_t mem_req,
	input wire cpu16_pkg::mem_rsp_t mem_rsp
);

	// instruction and data memories live outside
	core u_core (
		.clk(clk),
		.reset(reset),
		.instr_addr(instr_addr),
		.instruction(instruction),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

endmodule

`default_nettype wire

// ==== rtl/core.sv ====
`timescale 1ns/1ns
`default_nettype none

module core (
	input wire logic clk,
	input wire logic reset,
	output wire logic [cpu16_pkg::DATA_WIDTH-1:0] instr_addr,
	input wire logic [cpu16_pkg::WORD_WIDTH-1:0] instruction,
	output cpu16_pkg::mem_req_t mem_req,
	input wire cpu16_pkg::mem_rsp_t mem_rsp
);

	localparam int W = cpu16_pkg::DATA_WIDTH;
	localparam int FW = cpu16_pkg::FLAG_WIDTH;
	localparam int RW = cpu16_pkg::REG_CODE_WIDTH;

	cpu16_pkg::state_e state;
	cpu16_pkg::decoded_t dec;
	logic high_half;

	logic [W-1:0] rd_a;
	logic [W-1:0] rd_b;
	logic [W-1:0] op_a;
	logic [W-1:0] op_b;
	logic [W-1:0] result;
	logic [W-1:0] alu_result;
	logic [FW-1:0] flags;
	logic [FW-1:0] alu_flags;

	logic [RW-1:0] wr_code;
	logic [W-1:0] wr_data;
	logic [1:0] wr_lanes;
	logic ip_step;
	logic ip_write;
	logic is_alu;
	logic is_mem;

	instr_decoder u_decoder (
		.clk(clk),
		.reset(reset),
		.en(state == cpu16_pkg::ST_DECODE),
		.word(instruction),
		.high_half(high_half),
		.dec(dec)
	);

	alu u_alu (
		.op(dec.op),
		.a(op_a),
		.b(op_b),
		.cin(flags[cpu16_pkg::FLAG_C]),
		.result(alu_result),
		.flags(alu_flags)
	);

	// port a reads dest, port b reads src
	reg_file u_regs (
		.clk(clk),
		.reset(reset),
		.rd_a_code(dec.dest),
		.rd_b_code(dec.src),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.wr_code(wr_code),
		.wr_data(wr_data),
		.wr_lanes(wr_lanes),
		.ip_step(ip_step),
		.ip(instr_addr)
	);

	assign is_alu = dec.op inside {cpu16_pkg::OP_ADD, cpu16_pkg::OP_ADC, cpu16_pkg::OP_SUB,
		cpu16_pkg::OP_AND, cpu16_pkg::OP_OR, cpu16_pkg::OP_XOR, cpu16_pkg::OP_SHL,
		cpu16_pkg::OP_SHR};
	assign is_mem = (dec.op == cpu16_pkg::OP_LD) || (dec.op == cpu16_pkg::OP_ST);

	// single register write in save, picked by opcode
	always_comb begin
		wr_code = dec.dest;
		wr_data = result;
		wr_lanes = 2'b00;
		if (state == cpu16_pkg::ST_SAVE) begin
			case (dec.op)
				cpu16_pkg::OP_MOV: begin
					wr_data = op_b;
					wr_lanes = 2'b11;
				end
				cpu16_pkg::OP_MOVL: begin
					wr_data = {2{dec.imm}};
					wr_lanes = 2'b01;
				end
				cpu16_pkg::OP_MOVH: begin
					wr_data = {2{dec.imm}};
					wr_lanes = 2'b10;
				end
				cpu16_pkg::OP_MOVF: begin
					wr_data = {{(W-FW){1'b0}}, flags};
					wr_lanes = 2'b11;
				end
				cpu16_pkg::OP_JMP: begin
					wr_code = cpu16_pkg::REG_IP;
					wr_data = op_b;
					wr_lanes = 2'b11;
				end
				// result holds the read data on a load
				cpu16_pkg::OP_LD: wr_lanes = 2'b11;
				default: begin
					if (is_alu && dec.suffix) begin
						wr_lanes = 2'b11;
					end
				end
			endcase
		end
	end

	assign ip_write = (wr_code == cpu16_pkg::REG_IP) && (wr_lanes != 2'b00);
	// word done after the high half
	assign ip_step = (state == cpu16_pkg::ST_SAVE) && high_half;

	// operand and result latches
	always_ff @(posedge clk) begin
		if (state == cpu16_pkg::ST_READ) begin
			op_a <= rd_a;
			op_b <= rd_b;
		end
		if (state == cpu16_pkg::ST_EXEC) begin
			result <= alu_result;
		end
		if (state == cpu16_pkg::ST_MEM && mem_rsp.response) begin
			result <= mem_rsp.readdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu16_pkg::ST_DECODE;
			high_half <= 1'b0;
			flags <= '0;
			mem_req.request <= 1'b0;
			mem_req.wren <= 1'b0;
		end else begin
			case (state)
				cpu16_pkg::ST_DECODE: state <= cpu16_pkg::ST_READ;
				cpu16_pkg::ST_READ: state <= cpu16_pkg::ST_EXEC;
				cpu16_pkg::ST_EXEC: begin
					// flags follow every ALU op, suffix or not
					if (is_alu) begin
						flags <= alu_flags;
					end
					if (is_mem) begin
						mem_req.request <= 1'b1;
						mem_req.wren <= (dec.op == cpu16_pkg::OP_ST);
						// store addresses through dest, load through src
						mem_req.address <= (dec.op == cpu16_pkg::OP_ST) ? op_a : op_b;
						mem_req.writedata <= op_b;
						state <= cpu16_pkg::ST_MEM;
					end else begin
						state <= cpu16_pkg::ST_SAVE;
					end
				end
				cpu16_pkg::ST_MEM: begin
					if (mem_rsp.response) begin
						mem_req.request <= 1'b0;
						mem_req.wren <= 1'b0;
						state <= cpu16_pkg::ST_SAVE;
					end
				end
				cpu16_pkg::ST_SAVE: begin
					state <= cpu16_pkg::ST_DECODE;
					// a new ip always starts at the low half
					high_half <= ip_write ? 1'b0 : ~high_half;
				end
				default: state <= cpu16_pkg::ST_DECODE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic reset,
	input wire logic [cpu16_pkg::REG_CODE_WIDTH-1:0] rd_a_code,
	input wire logic [cpu16_pkg::REG_CODE_WIDTH-1:0] rd_b_code,
	output logic [cpu16_pkg::DATA_WIDTH-1:0] rd_a,
	output logic [cpu16_pkg::DATA_WIDTH-1:0] rd_b,
	input wire logic [cpu16_pkg::REG_CODE_WIDTH-1:0] wr_code,
	input wire logic [cpu16_pkg::DATA_WIDTH-1:0] wr_data,
	input wire logic [1:0] wr_lanes,
	input wire logic ip_step,
	output logic [cpu16_pkg::DATA_WIDTH-1:0] ip
);

	localparam int W = cpu16_pkg::DATA_WIDTH;
	localparam int REGS = 2 ** cpu16_pkg::REG_CODE_WIDTH;

	// r0..r5, sp, ip
	logic [W-1:0] regs [REGS];
	logic ip_written;

	assign rd_a = regs[rd_a_code];
	assign rd_b = regs[rd_b_code];
	assign ip = regs[cpu16_pkg::REG_IP];

	// an explicit write to ip wins over the step
	assign ip_written = (wr_code == cpu16_pkg::REG_IP) && (wr_lanes != 2'b00);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// lane 0 is the low byte, lane 1 the high byte
			if (wr_lanes[0]) begin
				regs[wr_code][W/2-1:0] <= wr_data[W/2-1:0];
			end
			if (wr_lanes[1]) begin
				regs[wr_code][W-1:W/2] <= wr_data[W-1:W/2];
			end
			if (ip_step && !ip_written) begin
				regs[cpu16_pkg::REG_IP] <= regs[cpu16_pkg::REG_IP] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
	input wire cpu16_pkg::op_e op,
	input wire logic [cpu16_pkg::DATA_WIDTH-1:0] a,
	input wire logic [cpu16_pkg::DATA_WIDTH-1:0] b,
	input wire logic cin,
	output logic [cpu16_pkg::DATA_WIDTH-1:0] result,
	output logic [cpu16_pkg::FLAG_WIDTH-1:0] flags
);

	localparam int W = cpu16_pkg::DATA_WIDTH;

	// one extra bit to catch carry or borrow
	logic [W:0] sum;
	logic carry;
	logic overflow;

	always_comb begin
		sum = '0;
		result = b;
		carry = 1'b0;
		overflow = 1'b0;

		case (op)
			cpu16_pkg::OP_ADD,
			cpu16_pkg::OP_ADC: begin
				sum = {1'b0, a} + {1'b0, b};
				if (op == cpu16_pkg::OP_ADC) begin
					sum = sum + {{W{1'b0}}, cin};
				end
				result = sum[W-1:0];
				carry = sum[W];
				overflow = (a[W-1] == b[W-1]) && (result[W-1] != a[W-1]);
			end
			cpu16_pkg::OP_SUB: begin
				// top bit of the wide difference is the borrow
				sum = {1'b0, a} - {1'b0, b};
				result = sum[W-1:0];
				carry = sum[W];
				overflow = (a[W-1] != b[W-1]) && (result[W-1] != a[W-1]);
			end
			cpu16_pkg::OP_AND: result = a & b;
			cpu16_pkg::OP_OR: result = a | b;
			cpu16_pkg::OP_XOR: result = a ^ b;
			cpu16_pkg::OP_SHL: begin
				result = {a[W-2:0], 1'b0};
				carry = a[W-1];
			end
			cpu16_pkg::OP_SHR: begin
				result = {1'b0, a[W-1:1]};
				carry = a[0];
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		flags = '0;
		flags[cpu16_pkg::FLAG_C] = carry;
		flags[cpu16_pkg::FLAG_S] = result[W-1];
		flags[cpu16_pkg::FLAG_O] = overflow;
		flags[cpu16_pkg::FLAG_Z] = (result == '0);
	end

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input wire logic clk,
	input wire logic reset,
	input wire logic en,
	input wire logic [cpu16_pkg::WORD_WIDTH-1:0] word,
	input wire logic high_half,
	output cpu16_pkg::decoded_t dec
);

	localparam int IW = cpu16_pkg::INSTR_WIDTH;
	localparam int WW = cpu16_pkg::WORD_WIDTH;

	logic [IW-1:0] half;
	cpu16_pkg::op_e op;
	cpu16_pkg::decoded_t next_dec;

	// low half runs first, then the high half of the same word
	assign half = high_half ? word[WW-1:IW] : word[IW-1:0];
	assign op = cpu16_pkg::op_e'(half[15:12]);

	always_comb begin
		next_dec.op = op;
		next_dec.dest = half[11:9];
		next_dec.src = half[8:6];
		next_dec.suffix = half[5];
		next_dec.imm = '0;

		case (op)
			// immediate moves reuse the src and suffix bits for the byte
			cpu16_pkg::OP_MOVL,
			cpu16_pkg::OP_MOVH: begin
				next_dec.src = '0;
				next_dec.suffix = 1'b0;
				next_dec.imm = half[7:0];
			end
			// no register write-back for these
			cpu16_pkg::OP_ST,
			cpu16_pkg::OP_JMP: begin
				next_dec.suffix = 1'b0;
			end
			cpu16_pkg::OP_NOP: begin
				next_dec.dest = '0;
				next_dec.src = '0;
				next_dec.suffix = 1'b0;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec <= '{op: cpu16_pkg::OP_NOP, default: '0};
		end else if (en) begin
			dec <= next_dec;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cpu16_pkg.sv ====
`default_nettype none

package cpu16_pkg;

	// datapath widths
	localparam int DATA_WIDTH = 16;
	localparam int INSTR_WIDTH = 16;
	localparam int WORD_WIDTH = 32;
	localparam int REG_CODE_WIDTH = 3;
	localparam int FLAG_WIDTH = 4;
	localparam int IMM_WIDTH = 8;

	// flag vector bit positions
	localparam int FLAG_C = 0;
	localparam int FLAG_S = 1;
	localparam int FLAG_O = 2;
	localparam int FLAG_Z = 3;

	localparam logic [REG_CODE_WIDTH-1:0] REG_SP = 3'd6;
	localparam logic [REG_CODE_WIDTH-1:0] REG_IP = 3'd7;

	// opcode field, bits 15..12 of an instruction
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_ADC  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SHL  = 4'h6,
		OP_SHR  = 4'h7,
		OP_MOV  = 4'h8,
		OP_MOVL = 4'h9,
		OP_MOVH = 4'ha,
		OP_MOVF = 4'hb,
		OP_JMP  = 4'hc,
		OP_LD   = 4'hd,
		OP_ST   = 4'he,
		OP_NOP  = 4'hf
	} op_e;

	typedef enum logic [2:0] {
		ST_DECODE = 3'd0,
		ST_READ   = 3'd1,
		ST_EXEC   = 3'd2,
		ST_MEM    = 3'd3,
		ST_SAVE   = 3'd4
	} state_e;

	typedef struct packed {
		op_e                       op;
		logic [REG_CODE_WIDTH-1:0] dest;
		logic [REG_CODE_WIDTH-1:0] src;
		logic                      suffix;
		logic [IMM_WIDTH-1:0]      imm;
	} decoded_t;

	// data bus, core to memory
	typedef struct packed {
		logic                  request;
		logic                  wren;
		logic [DATA_WIDTH-1:0] address;
		logic [DATA_WIDTH-1:0] writedata;
	} mem_req_t;

	// data bus, memory to core
	typedef struct packed {
		logic                  response;
		logic [DATA_WIDTH-1:0] readdata;
	} mem_rsp_t;

endpackage

`default_nettype wire
